//--- hdl/decodePkg.sv
`default_nettype none

package decodePkg;

    //////////////////////////////
    // widths with a meaning
    //////////////////////////////

    // instruction, data value or address
    typedef logic [31:0] word;
    typedef logic [4:0]  regAddr;
    typedef logic [4:0]  shamtField;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // primary opcode, bits 31..26
    typedef enum logic [5:0] {
        opRtype  = 6'h00,
        opRegimm = 6'h01,
        opJ      = 6'h02,
        opBeq    = 6'h04,
        opBne    = 6'h05,
        opBlez   = 6'h06,
        opBgtz   = 6'h07,
        opAddi   = 6'h08,
        opSlti   = 6'h0a,
        opAndi   = 6'h0c,
        opOri    = 6'h0d,
        opLw     = 6'h23,
        opSw     = 6'h2b
    } opcodeE;

    // r-type funct, bits 5..0
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    // zero means no alu work, so a no-op is all zeros
    typedef enum logic [3:0] {
        aluNone = 4'd0,
        aluAdd  = 4'd1,
        aluSub  = 4'd2,
        aluAnd  = 4'd3,
        aluOr   = 4'd4,
        aluSlt  = 4'd5,
        aluSll  = 4'd6,
        aluSrl  = 4'd7
    } aluOpE;

    // four-phase phases, shared by receiver and sender
    typedef enum logic [1:0] {
        hsIdle    = 2'd0,
        hsBusy    = 2'd1,
        hsRelease = 2'd2
    } hsStateE;

    //////////////////////////////
    // bundles
    //////////////////////////////

    typedef struct packed {
        word instr;
        word pcPlus4;
    } fetchItem;

    typedef struct packed {
        logic  regWrite;
        aluOpE aluOp;
        logic  aluSrc;
        logic  regDst;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  branchTaken;
        logic  jump;
        logic  jumpReg;
    } ctrlBits;

    // writeback from the later pipeline
    typedef struct packed {
        logic   en;
        regAddr addr;
        word    data;
    } wbPort;

    typedef struct packed {
        ctrlBits   ctrl;
        word       readData1;
        word       readData2;
        word       signExtImm;
        regAddr    rt;
        regAddr    rd;
        shamtField shamt;
        logic [5:0] funct;
        word       pcPlus4;
        word       branchTarget;
        word       jumpTarget;
    } issuePacket;

endpackage

`default_nettype wire

//--- hdl/fetchReceiver.sv
`default_nettype none

module fetchReceiver import decodePkg::*; (
    input  wire logic     Clk,
    input  wire logic     rstN,
    // four-phase channel from fetch
    input  wire logic     inReq,
    input  wire fetchItem inItem,
    output logic          inAck,
    // input slot toward the sender
    input  wire logic     slotTake,
    output logic          slotValid,
    output fetchItem      slotItem
);

    hsStateE  state;
    hsStateE  stateNext;
    logic     capture;
    logic     slotFull;
    fetchItem slotReg;

    // new capture only with ack low and the slot empty
    assign capture = (state == hsIdle) && inReq && !slotFull;

    always_comb begin
        stateNext = state;
        case (state)
            hsIdle: begin
                if (capture) begin
                    stateNext = hsBusy;
                end
            end
            hsBusy: begin
                // fetch saw the ack and dropped req
                if (!inReq) begin
                    stateNext = hsIdle;
                end
            end
            default: begin
                stateNext = hsIdle;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state    <= hsIdle;
            slotFull <= 1'b0;
        end else begin
            state <= stateNext;
            // capture and take never overlap, take needs a full slot
            if (capture) begin
                slotFull <= 1'b1;
            end else if (slotTake) begin
                slotFull <= 1'b0;
            end
        end
    end

    // payload only
    always_ff @(posedge Clk) begin
        if (capture) begin
            slotReg <= inItem;
        end
    end

    // ack rises on the capture edge
    assign inAck     = (state == hsBusy);
    assign slotValid = slotFull;
    assign slotItem  = slotReg;

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`default_nettype none

module registerFile import decodePkg::*; (
    input  wire logic   Clk,
    input  wire logic   rstN,
    // single write port from writeback
    input  wire wbPort  wb,
    // two combinational read ports
    input  wire regAddr readAddr1,
    input  wire regAddr readAddr2,
    output word         readData1,
    output word         readData2
);

    // r0 has no storage
    word regs [1:31];
    logic wrHit;

    // writes to r0 dropped here
    assign wrHit = wb.en && (wb.addr != 5'd0);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrHit) begin
            regs[wb.addr] <= wb.data;
        end
    end

    //////////////////////////////
    // read side
    //////////////////////////////

    // no bypass, returns the value from before this edge
    always_comb begin
        if (readAddr1 == 5'd0) begin
            readData1 = '0;
        end else begin
            readData1 = regs[readAddr1];
        end
    end

    always_comb begin
        if (readAddr2 == 5'd0) begin
            readData2 = '0;
        end else begin
            readData2 = regs[readAddr2];
        end
    end

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`default_nettype none

module controlUnit import decodePkg::*; (
    input  wire opcodeE opcode,
    input  wire functE  funct,
    // regimm selector
    input  wire regAddr rtField,
    // comparison flags from the core
    input  wire logic   equal,
    input  wire logic   lessZero,
    input  wire logic   greaterZero,
    output ctrlBits     ctrl
);

    always_comb begin
        // anything unlisted stays a no-op
        ctrl       = '0;
        ctrl.aluOp = aluNone;
        case (opcode)
            //////////////////////////////
            // r-type
            //////////////////////////////
            opRtype: begin
                case (funct)
                    fnAdd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = aluAdd;
                    end
                    fnSub: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = aluSub;
                    end
                    fnAnd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = aluAnd;
                    end
                    fnOr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = aluOr;
                    end
                    fnSlt: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = aluSlt;
                    end
                    // shifts take shamt from the packet
                    fnSll: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = aluSll;
                    end
                    fnSrl: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = 1'b1;
                        ctrl.aluOp    = aluSrl;
                    end
                    // jump through rs, nothing written
                    fnJr: begin
                        ctrl.jumpReg = 1'b1;
                    end
                    default: begin
                        ctrl.aluOp = aluNone;
                    end
                endcase
            end
            //////////////////////////////
            // immediates, rt destination
            //////////////////////////////
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opAndi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluAnd;
            end
            opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluOr;
            end
            opSlti: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluSlt;
            end
            // loads and stores add base and offset
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            // branches resolved here in decode
            opBeq: begin
                ctrl.branchTaken = equal;
            end
            opBne: begin
                ctrl.branchTaken = !equal;
            end
            // rs zero or negative
            opBlez: begin
                ctrl.branchTaken = !greaterZero;
            end
            opBgtz: begin
                ctrl.branchTaken = greaterZero;
            end
            // only bltz is decoded under regimm
            opRegimm: begin
                ctrl.branchTaken = (rtField == 5'd0) && lessZero;
            end
            opJ: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl.aluOp = aluNone;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/decodeCore.sv
`default_nettype none

module decodeCore import decodePkg::*; (
    input  wire logic     Clk,
    input  wire logic     rstN,
    // instruction from the input slot
    input  wire fetchItem item,
    input  wire wbPort    wb,
    output issuePacket    packet
);

    regAddr  rs;
    regAddr  rt;
    word     readData1;
    word     readData2;
    word     signExtImm;
    logic    equal;
    logic    lessZero;
    logic    greaterZero;
    ctrlBits ctrl;

    //////////////////////////////
    // field split
    //////////////////////////////

    assign rs = item.instr[25:21];
    assign rt = item.instr[20:16];

    registerFile regFile (
        .Clk       (Clk),
        .rstN      (rstN),
        .wb        (wb),
        .readAddr1 (rs),
        .readAddr2 (rt),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    // comparison flags for branch resolution
    assign equal       = (readData1 == readData2);
    assign lessZero    = readData1[31];
    assign greaterZero = !readData1[31] && (readData1 != '0);

    controlUnit ctrlUnit (
        .opcode      (opcodeE'(item.instr[31:26])),
        .funct       (functE'(item.instr[5:0])),
        .rtField     (rt),
        .equal       (equal),
        .lessZero    (lessZero),
        .greaterZero (greaterZero),
        .ctrl        (ctrl)
    );

    // 16-bit immediate to a full word
    assign signExtImm = {{16{item.instr[15]}}, item.instr[15:0]};

    //////////////////////////////
    // packet assembly
    //////////////////////////////

    always_comb begin
        packet.ctrl       = ctrl;
        packet.readData1  = readData1;
        packet.readData2  = readData2;
        packet.signExtImm = signExtImm;
        packet.rt         = rt;
        packet.rd         = item.instr[15:11];
        packet.shamt      = item.instr[10:6];
        packet.funct      = item.instr[5:0];
        packet.pcPlus4    = item.pcPlus4;
        // word offset relative to pc+4
        packet.branchTarget = item.pcPlus4 + {signExtImm[29:0], 2'b00};
        // region of pc+4 plus the 26-bit index
        packet.jumpTarget = {item.pcPlus4[31:28], item.instr[25:0], 2'b00};
    end

endmodule

`default_nettype wire

//--- hdl/issueSender.sv
`default_nettype none

module issueSender import decodePkg::*; (
    input  wire logic       Clk,
    input  wire logic       rstN,
    // from the input slot and the core
    input  wire logic       slotValid,
    input  wire issuePacket packetIn,
    output logic            slotTake,
    // four-phase channel toward execute
    input  wire logic       outAck,
    output logic            outReq,
    output issuePacket      outPacket
);

    hsStateE    state;
    hsStateE    stateNext;
    issuePacket packetReg;

    // output slot is empty only in idle
    assign slotTake = (state == hsIdle) && slotValid;

    always_comb begin
        stateNext = state;
        case (state)
            hsIdle: begin
                if (slotTake) begin
                    stateNext = hsBusy;
                end
            end
            // req held until execute acks
            hsBusy: begin
                if (outAck) begin
                    stateNext = hsRelease;
                end
            end
            // slot stays full until ack drops
            hsRelease: begin
                if (!outAck) begin
                    stateNext = hsIdle;
                end
            end
            default: begin
                stateNext = hsIdle;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= hsIdle;
        end else begin
            state <= stateNext;
        end
    end

    // packet loaded in the transfer cycle
    always_ff @(posedge Clk) begin
        if (slotTake) begin
            packetReg <= packetIn;
        end
    end

    assign outReq    = (state == hsBusy);
    assign outPacket = packetReg;

endmodule

`default_nettype wire

//--- hdl/decodeTop.sv
`default_nettype none

module decodeTop import decodePkg::*; (
    input  wire logic     Clk,
    input  wire logic     rstN,
    // fetch channel
    input  wire logic     inReq,
    input  wire fetchItem inItem,
    output logic          inAck,
    // issue channel
    input  wire logic     outAck,
    output logic          outReq,
    output issuePacket    outPacket,
    // register writeback
    input  wire wbPort    wb
);

    logic       slotValid;
    logic       slotTake;
    fetchItem   slotItem;
    issuePacket corePacket;

    //////////////////////////////
    // receiver, core, sender
    //////////////////////////////

    fetchReceiver receiver (
        .Clk       (Clk),
        .rstN      (rstN),
        .inReq     (inReq),
        .inItem    (inItem),
        .inAck     (inAck),
        .slotTake  (slotTake),
        .slotValid (slotValid),
        .slotItem  (slotItem)
    );

    // combinational decode of the held instruction
    decodeCore core (
        .Clk    (Clk),
        .rstN   (rstN),
        .item   (slotItem),
        .wb     (wb),
        .packet (corePacket)
    );

    issueSender sender (
        .Clk       (Clk),
        .rstN      (rstN),
        .slotValid (slotValid),
        .packetIn  (corePacket),
        .slotTake  (slotTake),
        .outAck    (outAck),
        .outReq    (outReq),
        .outPacket (outPacket)
    );

endmodule

`default_nettype wire

//--- sim/handshake_chk.sv
`default_nettype none

module handshakeChk import decodePkg::*; (
    input wire logic       Clk,
    input wire logic       rstN,
    // fetch channel
    input wire logic       inReq,
    input wire logic       inAck,
    // issue channel
    input wire logic       outReq,
    input wire logic       outAck,
    input wire issuePacket outPacket
);

    // count of failed assertions
    int errorCount = 0;

    //////////////////////////////
    // reset
    //////////////////////////////

    // one reset edge clears both outputs
    resetQuiet: assert property (@(posedge Clk) !rstN |=> !inAck && !outReq)
        else begin
            errorCount++;
            $error("inAck or outReq high while in reset");
        end

    //////////////////////////////
    // four-phase rules
    //////////////////////////////

    // fetch holds req until it sees ack
    inReqHeld: assert property (@(posedge Clk) disable iff (!rstN)
        inReq && !inAck |=> inReq || inAck)
        else begin
            errorCount++;
            $error("inReq dropped before inAck");
        end

    outReqHeld: assert property (@(posedge Clk) disable iff (!rstN)
        outReq && !outAck |=> outReq)
        else begin
            errorCount++;
            $error("outReq dropped before outAck");
        end

    // ack rises on the edge that saw req high
    inAckRise: assert property (@(posedge Clk) disable iff (!rstN)
        $rose(inAck) |-> $past(inReq))
        else begin
            errorCount++;
            $error("inAck rose without inReq");
        end

    outAckRise: assert property (@(posedge Clk) disable iff (!rstN)
        $rose(outAck) |-> outReq)
        else begin
            errorCount++;
            $error("outAck rose without outReq");
        end

    // packet frozen for the whole request
    packetStable: assert property (@(posedge Clk) disable iff (!rstN)
        outReq |=> !outReq || $stable(outPacket))
        else begin
            errorCount++;
            $error("outPacket changed while outReq high");
        end

endmodule

bind decodeTop handshakeChk chk (
    .Clk       (Clk),
    .rstN      (rstN),
    .inReq     (inReq),
    .inAck     (inAck),
    .outReq    (outReq),
    .outAck    (outAck),
    .outPacket (outPacket)
);

`default_nettype wire

//--- sim/decodeTb.sv
`default_nettype none

module decodeTb import decodePkg::*; ();

    localparam int waitLimit = 200;

    // one table row, expected targets filled in when the row is added
    typedef struct {
        string   name;
        word     instr;
        word     pcPlus4;
        ctrlBits ctrl;
        word     branchTarget;
        word     jumpTarget;
    } rowT;

    logic       Clk;
    logic       rstN;
    logic       inReq;
    fetchItem   inItem;
    logic       inAck;
    logic       outAck;
    logic       outReq;
    issuePacket outPacket;
    wbPort      wb;

    rowT         rows[$];
    // register model, r0 never written
    word         regModel[32];
    logic [31:0] rngState;

    decodeTop uut (
        .Clk       (Clk),
        .rstN      (rstN),
        .inReq     (inReq),
        .inItem    (inItem),
        .inAck     (inAck),
        .outAck    (outAck),
        .outReq    (outReq),
        .outPacket (outPacket),
        .wb        (wb)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    // bound handshake assertions count their failures
    always @(posedge Clk) begin
        #1;
        assert (uut.chk.errorCount == 0) else begin
            $display("a handshake protocol assertion failed");
            failRun();
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // xorshift32 step
    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // mips encodings
    function automatic word encR(regAddr rs, regAddr rt, regAddr rd, shamtField sh,
                                 logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word encI(logic [5:0] op, regAddr rs, regAddr rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word encJ(logic [5:0] op, logic [25:0] index);
        return {op, index};
    endfunction

    // expected control per class
    function automatic ctrlBits rtypeCtrl(aluOpE op);
        ctrlBits c;
        c          = '0;
        c.regWrite = 1'b1;
        c.regDst   = 1'b1;
        c.aluOp    = op;
        return c;
    endfunction

    function automatic ctrlBits immCtrl(aluOpE op);
        ctrlBits c;
        c          = '0;
        c.regWrite = 1'b1;
        c.aluSrc   = 1'b1;
        c.aluOp    = op;
        return c;
    endfunction

    function automatic ctrlBits memCtrl(logic load);
        ctrlBits c;
        c          = '0;
        c.aluSrc   = 1'b1;
        c.aluOp    = aluAdd;
        c.regWrite = load;
        c.memRead  = load;
        c.memToReg = load;
        c.memWrite = !load;
        return c;
    endfunction

    function automatic ctrlBits branchCtrl(logic taken);
        ctrlBits c;
        c             = '0;
        c.branchTaken = taken;
        return c;
    endfunction

    function automatic ctrlBits jumpCtrl(logic viaReg);
        ctrlBits c;
        c         = '0;
        c.jump    = !viaReg;
        c.jumpReg = viaReg;
        return c;
    endfunction

    task automatic addRow(string name, word instr, word pc, ctrlBits ctrl);
        rowT r;
        word imm;
        imm            = {{16{instr[15]}}, instr[15:0]};
        r.name         = name;
        r.instr        = instr;
        r.pcPlus4      = pc;
        r.ctrl         = ctrl;
        r.branchTarget = pc + (imm << 2);
        r.jumpTarget   = {pc[31:28], instr[25:0], 2'b00};
        rows.push_back(r);
    endtask

    task automatic failRun();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkValue(string test, string field, word expected, word actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: %s expected %h actual %h", test, field, expected, actual);
            failRun();
        end
    endtask

    task automatic checkPacket(rowT r);
        word imm;
        imm = {{16{r.instr[15]}}, r.instr[15:0]};
        checkValue(r.name, "ctrl", r.ctrl, outPacket.ctrl);
        checkValue(r.name, "readData1", regModel[r.instr[25:21]], outPacket.readData1);
        checkValue(r.name, "readData2", regModel[r.instr[20:16]], outPacket.readData2);
        checkValue(r.name, "signExtImm", imm, outPacket.signExtImm);
        checkValue(r.name, "rt", r.instr[20:16], outPacket.rt);
        checkValue(r.name, "rd", r.instr[15:11], outPacket.rd);
        checkValue(r.name, "shamt", r.instr[10:6], outPacket.shamt);
        checkValue(r.name, "funct", r.instr[5:0], outPacket.funct);
        checkValue(r.name, "pcPlus4", r.pcPlus4, outPacket.pcPlus4);
        checkValue(r.name, "branchTarget", r.branchTarget, outPacket.branchTarget);
        checkValue(r.name, "jumpTarget", r.jumpTarget, outPacket.jumpTarget);
    endtask

    // one writeback cycle, model follows the r0 rule
    task automatic writeReg(regAddr a, word d);
        wb.en   = 1'b1;
        wb.addr = a;
        wb.data = d;
        @(posedge Clk);
        #2;
        wb.en = 1'b0;
        if (a != 5'd0) begin
            regModel[a] = d;
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    task automatic buildTable();
        // r-type
        addRow("add", encR(1, 4, 8, 0, 6'h20), 32'h0040_0004, rtypeCtrl(aluAdd));
        addRow("sub", encR(4, 3, 9, 0, 6'h22), 32'h1000_0010, rtypeCtrl(aluSub));
        addRow("and", encR(3, 4, 10, 0, 6'h24), 32'h8000_0100, rtypeCtrl(aluAnd));
        addRow("or", encR(6, 7, 11, 0, 6'h25), 32'hbfc0_0008, rtypeCtrl(aluOr));
        addRow("slt", encR(3, 1, 12, 0, 6'h2a), 32'hf000_fffc, rtypeCtrl(aluSlt));
        addRow("sll", encR(0, 4, 13, 7, 6'h00), 32'h0040_0020, rtypeCtrl(aluSll));
        addRow("srl", encR(0, 6, 14, 31, 6'h02), 32'h7fff_fff0, rtypeCtrl(aluSrl));
        addRow("jr", encR(4, 0, 0, 0, 6'h08), 32'h2000_0040, jumpCtrl(1'b1));
        addRow("add r0 read", encR(0, 1, 15, 0, 6'h20), 32'h0040_0044, rtypeCtrl(aluAdd));
        addRow("rtype bad funct", encR(1, 2, 3, 0, 6'h27), 32'h0040_0048, '0);
        // immediates, loads and stores
        addRow("addi", encI(6'h08, 1, 16, 16'hfffc), 32'h3000_0100, immCtrl(aluAdd));
        addRow("andi", encI(6'h0c, 4, 17, 16'h00ff), 32'h9000_0004, immCtrl(aluAnd));
        addRow("ori", encI(6'h0d, 3, 18, 16'h8000), 32'h0000_8000, immCtrl(aluOr));
        addRow("slti", encI(6'h0a, 3, 19, 16'h0010), 32'he000_0200, immCtrl(aluSlt));
        addRow("lw", encI(6'h23, 4, 20, 16'h0008), 32'h1000_0400, memCtrl(1'b1));
        addRow("sw", encI(6'h2b, 6, 7, 16'hfff0), 32'hc000_0010, memCtrl(1'b0));
        // branches, taken and not taken
        addRow("beq taken", encI(6'h04, 1, 2, 16'h0010), 32'h0040_1000, branchCtrl(1'b1));
        addRow("beq not", encI(6'h04, 1, 4, 16'hfff8), 32'h0040_1004, branchCtrl(1'b0));
        addRow("bne taken", encI(6'h05, 1, 4, 16'h8000), 32'h5000_0000, branchCtrl(1'b1));
        addRow("bne not", encI(6'h05, 1, 2, 16'h0004), 32'h5000_0004, branchCtrl(1'b0));
        addRow("blez zero", encI(6'h06, 5, 0, 16'h0020), 32'h0040_2000, branchCtrl(1'b1));
        addRow("blez neg", encI(6'h06, 3, 0, 16'hffe0), 32'h0040_2004, branchCtrl(1'b1));
        addRow("blez not", encI(6'h06, 1, 0, 16'h0020), 32'h0040_2008, branchCtrl(1'b0));
        addRow("bgtz taken", encI(6'h07, 1, 0, 16'h7fff), 32'ha000_0000, branchCtrl(1'b1));
        addRow("bgtz neg", encI(6'h07, 3, 0, 16'h0001), 32'ha000_0004, branchCtrl(1'b0));
        addRow("bgtz zero", encI(6'h07, 5, 0, 16'h0001), 32'ha000_0008, branchCtrl(1'b0));
        addRow("bltz taken", encI(6'h01, 3, 0, 16'hff00), 32'h0040_3000, branchCtrl(1'b1));
        addRow("bltz min", encI(6'h01, 6, 0, 16'h0100), 32'h0040_3004, branchCtrl(1'b1));
        addRow("bltz not", encI(6'h01, 1, 0, 16'h0100), 32'h0040_3008, branchCtrl(1'b0));
        // regimm with rt 1 is outside the set
        addRow("regimm rt1", encI(6'h01, 3, 1, 16'h0100), 32'h0040_300c, '0);
        // jumps and unknown opcodes
        addRow("j", encJ(6'h02, 26'h012_3456), 32'hbfc0_0008, jumpCtrl(1'b0));
        addRow("jal unknown", encJ(6'h03, 26'h000_0040), 32'h6000_0000, '0);
        addRow("opcode 3f", encJ(6'h3f, 26'h3ff_ffff), 32'hd000_0000, '0);
    endtask

    //////////////////////////////
    // channel drivers
    //////////////////////////////

    // fetch side, one four-phase cycle per row
    task automatic runFetch();
        int count;
        foreach (rows[i]) begin
            inItem.instr   = rows[i].instr;
            inItem.pcPlus4 = rows[i].pcPlus4;
            inReq          = 1'b1;
            count          = 0;
            do begin
                @(posedge Clk);
                #1;
                count++;
                if (count > waitLimit) begin
                    $display("fetch: inAck never rose for %s", rows[i].name);
                    failRun();
                end
            end while (!inAck);
            #1;
            inReq = 1'b0;
            count = 0;
            do begin
                @(posedge Clk);
                #1;
                count++;
                if (count > waitLimit) begin
                    $display("fetch: inAck never fell for %s", rows[i].name);
                    failRun();
                end
            end while (inAck);
            #1;
        end
    endtask

    // execute side, random ack delay 0 to 7 cycles
    task automatic runExecute();
        int count;
        int delay;
        foreach (rows[i]) begin
            count = 0;
            do begin
                @(posedge Clk);
                #1;
                count++;
                if (count > waitLimit) begin
                    $display("execute: outReq never rose for %s", rows[i].name);
                    failRun();
                end
            end while (!outReq);
            // packets must come in table order
            checkPacket(rows[i]);
            rngState = nextRandom(rngState);
            delay    = rngState % 8;
            #1;
            repeat (delay) begin
                @(posedge Clk);
                #2;
            end
            outAck = 1'b1;
            count  = 0;
            do begin
                @(posedge Clk);
                #1;
                count++;
                if (count > waitLimit) begin
                    $display("execute: outReq never fell for %s", rows[i].name);
                    failRun();
                end
            end while (outReq);
            #1;
            outAck = 1'b0;
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rstN     = 1'b0;
        inReq    = 1'b0;
        inItem   = '0;
        outAck   = 1'b0;
        wb       = '0;
        rngState = 32'hde15_437c;
        foreach (regModel[i]) begin
            regModel[i] = '0;
        end
        repeat (4) @(posedge Clk);
        #2;
        rstN = 1'b1;
        // both channels quiet with no fetch yet
        repeat (5) begin
            @(posedge Clk);
            #1;
            checkValue("reset", "inAck", 32'd0, inAck);
            checkValue("reset", "outReq", 32'd0, outReq);
            #1;
        end
        // r5 left at its reset value, r0 write dropped
        writeReg(5'd1, 32'h0000_0005);
        writeReg(5'd2, 32'h0000_0005);
        writeReg(5'd3, 32'hffff_fff0);
        writeReg(5'd4, 32'h1234_5678);
        writeReg(5'd6, 32'h8000_0000);
        writeReg(5'd7, 32'h0f0f_00ff);
        writeReg(5'd0, 32'hdead_beef);
        buildTable();
        fork
            runFetch();
            runExecute();
        join
        // every packet arrives once
        repeat (10) begin
            @(posedge Clk);
            #1;
            checkValue("drain", "outReq", 32'd0, outReq);
            #1;
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/decodePkg.sv
hdl/fetchReceiver.sv
hdl/registerFile.sv
hdl/controlUnit.sv
hdl/decodeCore.sv
hdl/issueSender.sv
hdl/decodeTop.sv
sim/handshake_chk.sv
sim/decodeTb.sv
